// ==== design/dcache_pkg.sv ====
package dcache_pkg;

    localparam int way_num    = 4;
    localparam int line_words = 4;
    localparam int set_num    = 16;

    localparam int offset_bits = 4;   // 16 bytes per line
    localparam int index_bits  = 4;
    localparam int tag_bits    = 24;

    typedef logic [31:0]                addr_t;
    typedef logic [31:0]                word_t;
    typedef logic [line_words*32-1:0]   line_t;  // word i at [32*i +: 32]
    typedef logic [tag_bits-1:0]        tag_t;
    typedef logic [index_bits-1:0]      index_t;
    typedef logic [1:0]                 way_t;
    typedef logic [3:0]                 strb_t;
    typedef logic [1:0]                 size_t;  // 0 byte, 1 half, 2 word

    // one request at a time, four-phase on every port
    typedef enum logic [2:0] {
        LOOKUP,
        WB_REQ,
        WB_DONE,
        FILL_REQ,
        FILL_DONE,
        UNC_REQ,
        UNC_DONE,
        RESP
    } ctrl_state_t;

endpackage

// ==== design/load_align.sv ====
module load_align (
    input  dcache_pkg::word_t word,
    input  logic [1:0]        offset,
    input  dcache_pkg::size_t size,
    input  logic              sign,
    output dcache_pkg::word_t rdata
);

    dcache_pkg::word_t shifted;

    assign shifted = word >> {offset, 3'b000};   // addressed byte to bit 0

    always_comb begin
        case (size)
            2'd0: begin
                if (sign)
                    rdata = {{24{shifted[7]}}, shifted[7:0]};
                else
                    rdata = {24'b0, shifted[7:0]};
            end
            2'd1: begin
                if (sign)
                    rdata = {{16{shifted[15]}}, shifted[15:0]};
                else
                    rdata = {16'b0, shifted[15:0]};
            end
            default: rdata = word;               // full word as is
        endcase
    end

endmodule

// ==== design/plru_tree.sv ====
module plru_tree (
    input  logic               clk,
    input  logic               rst_n,
    input  dcache_pkg::index_t index,
    input  logic               touch,
    input  dcache_pkg::way_t   way,
    output dcache_pkg::way_t   victim
);

    // bit 0 root, bit 1 picks in ways 0/1, bit 2 picks in ways 2/3
    logic [2:0] tree_q [dcache_pkg::set_num];
    logic [2:0] cur;

    assign cur = tree_q[index];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < dcache_pkg::set_num; s++)
                tree_q[s] <= '0;
        end else if (touch) begin
            tree_q[index][0] <= !way[1];         // point at the other half
            if (way[1])
                tree_q[index][2] <= !way[0];
            else
                tree_q[index][1] <= !way[0];
        end
    end

    assign victim = cur[0] ? {1'b1, cur[2]} : {1'b0, cur[1]};

endmodule

// ==== design/dcache_arrays.sv ====
module dcache_arrays (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  dcache_pkg::index_t                          index,
    input  logic [dcache_pkg::way_num-1:0]              we,
    input  dcache_pkg::tag_t                            wtag,
    input  logic                                        wdirty,
    input  dcache_pkg::line_t                           wline,
    output logic [dcache_pkg::way_num-1:0]              valid,
    output logic [dcache_pkg::way_num-1:0]              dirty,
    output dcache_pkg::tag_t [dcache_pkg::way_num-1:0]  tags,
    output dcache_pkg::line_t [dcache_pkg::way_num-1:0] lines
);

    logic [dcache_pkg::set_num-1:0] valid_q [dcache_pkg::way_num];
    logic [dcache_pkg::set_num-1:0] dirty_q [dcache_pkg::way_num];
    dcache_pkg::tag_t               tag_mem [dcache_pkg::way_num][dcache_pkg::set_num];
    dcache_pkg::line_t              line_mem [dcache_pkg::way_num][dcache_pkg::set_num];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int w = 0; w < dcache_pkg::way_num; w++)
                valid_q[w] <= '0;
        end else begin
            for (int w = 0; w < dcache_pkg::way_num; w++) begin
                if (we[w])
                    valid_q[w][index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < dcache_pkg::way_num; w++) begin
            if (we[w]) begin
                dirty_q[w][index]  <= wdirty;
                tag_mem[w][index]  <= wtag;
                line_mem[w][index] <= wline;
            end
        end
    end

    always_comb begin
        for (int w = 0; w < dcache_pkg::way_num; w++) begin
            valid[w] = valid_q[w][index];        // async read
            dirty[w] = dirty_q[w][index];
            tags[w]  = tag_mem[w][index];
            lines[w] = line_mem[w][index];
        end
    end

endmodule

// ==== design/dcache_ctrl.sv ====
module dcache_ctrl (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        cpu_req,
    input  logic                                        cpu_we,
    input  logic                                        cpu_cached,
    input  dcache_pkg::addr_t                           cpu_addr,
    input  dcache_pkg::word_t                           cpu_wdata,
    input  dcache_pkg::strb_t                           cpu_wstrb,
    input  dcache_pkg::size_t                           cpu_size,
    input  logic                                        cpu_signed,
    input  logic                                        mem_ack,
    input  dcache_pkg::line_t                           mem_rline,
    input  logic                                        unc_ack,
    input  dcache_pkg::word_t                           unc_rdata,
    input  logic [dcache_pkg::way_num-1:0]              rd_valid,
    input  logic [dcache_pkg::way_num-1:0]              rd_dirty,
    input  dcache_pkg::tag_t [dcache_pkg::way_num-1:0]  rd_tags,
    input  dcache_pkg::line_t [dcache_pkg::way_num-1:0] rd_lines,
    input  dcache_pkg::way_t                            victim,
    output logic                                        cpu_ack,
    output logic                                        mem_req,
    output logic                                        mem_we,
    output dcache_pkg::addr_t                           mem_addr,
    output dcache_pkg::line_t                           mem_wline,
    output logic                                        unc_req,
    output logic                                        unc_we,
    output dcache_pkg::addr_t                           unc_addr,
    output dcache_pkg::word_t                           unc_wdata,
    output dcache_pkg::strb_t                           unc_wstrb,
    output dcache_pkg::index_t                          arr_index,
    output logic [dcache_pkg::way_num-1:0]              arr_we,
    output dcache_pkg::tag_t                            arr_tag,
    output logic                                        arr_dirty,
    output dcache_pkg::line_t                           arr_line,
    output logic                                        lru_touch,
    output dcache_pkg::way_t                            lru_way,
    output dcache_pkg::word_t                           resp_word,
    output logic [1:0]                                  resp_offset,
    output dcache_pkg::size_t                           resp_size,
    output logic                                        resp_signed
);

    dcache_pkg::ctrl_state_t        state;
    dcache_pkg::ctrl_state_t        state_next;
    logic                           req_vld;
    logic                           req_we;
    logic                           req_cached;
    logic                           req_signed;
    dcache_pkg::addr_t              req_addr;
    dcache_pkg::word_t              req_wdata;
    dcache_pkg::strb_t              req_wstrb;
    dcache_pkg::size_t              req_size;
    dcache_pkg::way_t               vict_q;
    dcache_pkg::word_t              unc_q;
    dcache_pkg::tag_t               req_tag;
    logic [1:0]                     word_sel;
    logic                           take;
    logic                           lookup_go;
    logic                           fill;
    logic                           store_hit;
    logic [dcache_pkg::way_num-1:0] hit;
    logic                           hit_any;
    dcache_pkg::way_t               hit_way;
    dcache_pkg::line_t              hit_line;
    dcache_pkg::word_t              hit_word;
    dcache_pkg::word_t              merged_word;
    dcache_pkg::line_t              merged_line;

    assign req_tag   = req_addr[31 -: dcache_pkg::tag_bits];
    assign arr_index = req_addr[dcache_pkg::offset_bits +: dcache_pkg::index_bits];
    assign word_sel  = req_addr[dcache_pkg::offset_bits-1:2];
    assign take      = (state == dcache_pkg::LOOKUP) && !req_vld && cpu_req && !cpu_ack;
    assign lookup_go = (state == dcache_pkg::LOOKUP) && req_vld;

    always_ff @(posedge clk) begin
        if (take) begin
            req_we     <= cpu_we;
            req_cached <= cpu_cached;
            req_signed <= cpu_signed;
            req_addr   <= cpu_addr;
            req_wdata  <= cpu_wdata;
            req_wstrb  <= cpu_wstrb;
            req_size   <= cpu_size;
        end
        if (lookup_go && req_cached && !hit_any)
            vict_q <= victim;                    // held for writeback and refill
        if (state == dcache_pkg::UNC_REQ && unc_ack)
            unc_q <= unc_rdata;
    end

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < dcache_pkg::way_num; w++) begin
            hit[w] = rd_valid[w] && (rd_tags[w] == req_tag);
            if (hit[w])
                hit_way = dcache_pkg::way_t'(w);
        end
    end

    assign hit_any  = |hit;
    assign hit_line = rd_lines[hit_way];
    assign hit_word = hit_line[32*word_sel +: 32];

    always_comb begin
        merged_word = hit_word;
        for (int b = 0; b < 4; b++) begin
            if (req_wstrb[b])
                merged_word[8*b +: 8] = req_wdata[8*b +: 8];
        end
        merged_line                    = hit_line;
        merged_line[32*word_sel +: 32] = merged_word;
    end

    always_comb begin
        state_next = state;
        case (state)
            dcache_pkg::LOOKUP: begin
                if (lookup_go) begin
                    if (!req_cached)
                        state_next = dcache_pkg::UNC_REQ;
                    else if (hit_any)
                        state_next = dcache_pkg::RESP;
                    else if (rd_valid[victim] && rd_dirty[victim])
                        state_next = dcache_pkg::WB_REQ;
                    else
                        state_next = dcache_pkg::FILL_REQ;
                end
            end
            dcache_pkg::WB_REQ:    if (mem_ack) state_next = dcache_pkg::WB_DONE;
            dcache_pkg::WB_DONE:   if (!mem_ack) state_next = dcache_pkg::FILL_REQ;
            dcache_pkg::FILL_REQ:  if (mem_ack) state_next = dcache_pkg::FILL_DONE;
            dcache_pkg::FILL_DONE: if (!mem_ack) state_next = dcache_pkg::LOOKUP; // rerun, hits
            dcache_pkg::UNC_REQ:   if (unc_ack) state_next = dcache_pkg::UNC_DONE;
            dcache_pkg::UNC_DONE:  if (!unc_ack) state_next = dcache_pkg::RESP;
            dcache_pkg::RESP:      if (!cpu_req) state_next = dcache_pkg::LOOKUP;
            default:               state_next = dcache_pkg::LOOKUP;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= dcache_pkg::LOOKUP;
            req_vld <= 1'b0;
        end else begin
            state <= state_next;
            if (take)
                req_vld <= 1'b1;
            else if (state_next == dcache_pkg::RESP)
                req_vld <= 1'b0;
        end
    end

    assign cpu_ack = (state == dcache_pkg::RESP);

    assign mem_req   = (state == dcache_pkg::WB_REQ) || (state == dcache_pkg::FILL_REQ);
    assign mem_we    = (state == dcache_pkg::WB_REQ);
    assign mem_addr  = (state == dcache_pkg::WB_REQ || state == dcache_pkg::WB_DONE) ?
                       {rd_tags[vict_q], arr_index, {dcache_pkg::offset_bits{1'b0}}} :
                       {req_tag, arr_index, {dcache_pkg::offset_bits{1'b0}}};
    assign mem_wline = rd_lines[vict_q];

    assign unc_req   = (state == dcache_pkg::UNC_REQ);
    assign unc_we    = req_we;
    assign unc_addr  = req_addr;
    assign unc_wdata = req_wdata;
    assign unc_wstrb = req_wstrb;

    assign fill      = (state == dcache_pkg::FILL_REQ) && mem_ack;
    assign store_hit = lookup_go && req_cached && hit_any && req_we;

    always_comb begin
        arr_we = '0;
        if (fill)
            arr_we[vict_q] = 1'b1;
        else if (store_hit)
            arr_we = hit;
    end

    assign arr_tag   = req_tag;
    assign arr_dirty = !fill;                    // refill lands clean
    assign arr_line  = fill ? mem_rline : merged_line;

    assign lru_touch = lookup_go && req_cached && hit_any;
    assign lru_way   = hit_way;

    assign resp_word   = req_cached ? hit_word : unc_q;
    assign resp_offset = req_addr[1:0];
    assign resp_size   = req_size;
    assign resp_signed = req_signed;

endmodule

// ==== design/dcache_top.sv ====
module dcache_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cpu_req,
    input  logic                cpu_we,
    input  logic                cpu_cached,
    input  dcache_pkg::addr_t   cpu_addr,
    input  dcache_pkg::word_t   cpu_wdata,
    input  dcache_pkg::strb_t   cpu_wstrb,
    input  dcache_pkg::size_t   cpu_size,
    input  logic                cpu_signed,
    output logic                cpu_ack,
    output dcache_pkg::word_t   cpu_rdata,
    output logic                mem_req,
    output logic                mem_we,
    output dcache_pkg::addr_t   mem_addr,
    output dcache_pkg::line_t   mem_wline,
    input  logic                mem_ack,
    input  dcache_pkg::line_t   mem_rline,
    output logic                unc_req,
    output logic                unc_we,
    output dcache_pkg::addr_t   unc_addr,
    output dcache_pkg::word_t   unc_wdata,
    output dcache_pkg::strb_t   unc_wstrb,
    input  logic                unc_ack,
    input  dcache_pkg::word_t   unc_rdata
);

    logic [dcache_pkg::way_num-1:0]               rd_valid;
    logic [dcache_pkg::way_num-1:0]               rd_dirty;
    dcache_pkg::tag_t [dcache_pkg::way_num-1:0]   rd_tags;
    dcache_pkg::line_t [dcache_pkg::way_num-1:0]  rd_lines;
    dcache_pkg::way_t                             victim;
    dcache_pkg::index_t                           arr_index;
    logic [dcache_pkg::way_num-1:0]               arr_we;
    dcache_pkg::tag_t                             arr_tag;
    logic                                         arr_dirty;
    dcache_pkg::line_t                            arr_line;
    logic                                         lru_touch;
    dcache_pkg::way_t                             lru_way;
    dcache_pkg::word_t                            resp_word;
    logic [1:0]                                   resp_offset;
    dcache_pkg::size_t                            resp_size;
    logic                                         resp_signed;

    dcache_ctrl ctrl_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .cpu_req     (cpu_req),
        .cpu_we      (cpu_we),
        .cpu_cached  (cpu_cached),
        .cpu_addr    (cpu_addr),
        .cpu_wdata   (cpu_wdata),
        .cpu_wstrb   (cpu_wstrb),
        .cpu_size    (cpu_size),
        .cpu_signed  (cpu_signed),
        .mem_ack     (mem_ack),
        .mem_rline   (mem_rline),
        .unc_ack     (unc_ack),
        .unc_rdata   (unc_rdata),
        .rd_valid    (rd_valid),
        .rd_dirty    (rd_dirty),
        .rd_tags     (rd_tags),
        .rd_lines    (rd_lines),
        .victim      (victim),
        .cpu_ack     (cpu_ack),
        .mem_req     (mem_req),
        .mem_we      (mem_we),
        .mem_addr    (mem_addr),
        .mem_wline   (mem_wline),
        .unc_req     (unc_req),
        .unc_we      (unc_we),
        .unc_addr    (unc_addr),
        .unc_wdata   (unc_wdata),
        .unc_wstrb   (unc_wstrb),
        .arr_index   (arr_index),
        .arr_we      (arr_we),
        .arr_tag     (arr_tag),
        .arr_dirty   (arr_dirty),
        .arr_line    (arr_line),
        .lru_touch   (lru_touch),
        .lru_way     (lru_way),
        .resp_word   (resp_word),
        .resp_offset (resp_offset),
        .resp_size   (resp_size),
        .resp_signed (resp_signed)
    );

    dcache_arrays arrays_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .index  (arr_index),
        .we     (arr_we),
        .wtag   (arr_tag),
        .wdirty (arr_dirty),
        .wline  (arr_line),
        .valid  (rd_valid),
        .dirty  (rd_dirty),
        .tags   (rd_tags),
        .lines  (rd_lines)
    );

    plru_tree plru_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .index  (arr_index),
        .touch  (lru_touch),
        .way    (lru_way),
        .victim (victim)
    );

    load_align align_i (
        .word   (resp_word),
        .offset (resp_offset),
        .size   (resp_size),
        .sign   (resp_signed),
        .rdata  (cpu_rdata)
    );

endmodule

// ==== tb/dcache_chk.sv ====
module dcache_chk (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cpu_req,
    input  logic              cpu_we,
    input  logic              cpu_cached,
    input  dcache_pkg::addr_t cpu_addr,
    input  dcache_pkg::word_t cpu_wdata,
    input  dcache_pkg::strb_t cpu_wstrb,
    input  dcache_pkg::size_t cpu_size,
    input  logic              cpu_signed,
    input  logic              cpu_ack,
    input  dcache_pkg::word_t cpu_rdata,
    input  logic              mem_req,
    input  logic              mem_we,
    input  dcache_pkg::addr_t mem_addr,
    input  dcache_pkg::line_t mem_wline,
    input  logic              mem_ack,
    input  logic              unc_req,
    input  logic              unc_we,
    input  dcache_pkg::addr_t unc_addr,
    input  dcache_pkg::word_t unc_wdata,
    input  dcache_pkg::strb_t unc_wstrb,
    input  logic              unc_ack
);

    dcache_pkg::word_t              shadow [2048];   // cached words, then uncached at 1024
    int                             fail_count = 0;
    logic                           ack_q;
    logic                           req_q;
    logic                           hit_pending;
    logic                           unc_pending;
    logic                           recent_hit;
    dcache_pkg::tag_t               recent0 [dcache_pkg::set_num];
    dcache_pkg::tag_t               recent1 [dcache_pkg::set_num];
    logic [dcache_pkg::set_num-1:0] recent0_v;
    logic [dcache_pkg::set_num-1:0] recent1_v;
    dcache_pkg::tag_t               cur_tag;
    dcache_pkg::index_t             cur_set;
    dcache_pkg::word_t              shadow_word;
    dcache_pkg::word_t              shifted;
    dcache_pkg::word_t              exp_rdata;

    assign cur_tag     = cpu_addr[31 -: dcache_pkg::tag_bits];
    assign cur_set     = cpu_addr[dcache_pkg::offset_bits +: dcache_pkg::index_bits];
    // tree plru never evicts either of the two most recent lines of a set
    assign recent_hit  = cpu_cached && ((recent0_v[cur_set] && recent0[cur_set] == cur_tag) ||
                                        (recent1_v[cur_set] && recent1[cur_set] == cur_tag));
    assign shadow_word = shadow[cpu_addr[12:2]];
    assign shifted     = shadow_word >> (8 * cpu_addr[1:0]);

    always_comb begin
        case (cpu_size)
            2'd0:    exp_rdata = {{24{cpu_signed & shifted[7]}}, shifted[7:0]};
            2'd1:    exp_rdata = {{16{cpu_signed & shifted[15]}}, shifted[15:0]};
            default: exp_rdata = shadow_word;
        endcase
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q       <= 1'b0;
            req_q       <= 1'b0;
            hit_pending <= 1'b0;
            unc_pending <= 1'b0;
            recent0_v   <= '0;
            recent1_v   <= '0;
        end else begin
            ack_q <= cpu_ack;
            req_q <= cpu_req;
            if (cpu_req && !req_q) begin
                hit_pending <= recent_hit;
                unc_pending <= !cpu_cached;
            end else if (cpu_ack) begin
                hit_pending <= 1'b0;
                unc_pending <= 1'b0;
            end
            if (cpu_ack && !ack_q && cpu_cached &&
                !(recent0_v[cur_set] && recent0[cur_set] == cur_tag)) begin
                recent1[cur_set]   <= recent0[cur_set];
                recent1_v[cur_set] <= recent0_v[cur_set];
                recent0[cur_set]   <= cur_tag;
                recent0_v[cur_set] <= 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n && cpu_ack && !ack_q && cpu_we) begin
            for (int b = 0; b < 4; b++) begin
                if (cpu_wstrb[b])
                    shadow[cpu_addr[12:2]][8*b +: 8] <= cpu_wdata[8*b +: 8];
            end
        end
    end

    load_data: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(cpu_ack) && !cpu_we |-> cpu_rdata == exp_rdata)
        else begin
            fail_count++;
            $error("CHECK FAILED cpu_rdata at %h: got %h, expected %h",
                   $sampled(cpu_addr), $sampled(cpu_rdata), $sampled(exp_rdata));
        end

    // ack is set one edge after the take edge and sampled one edge later
    hit_latency: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(cpu_req) && recent_hit |-> ##2 $rose(cpu_ack))
        else begin
            fail_count++;
            $error("CHECK FAILED cpu_ack: hit at %h was not acknowledged in 2 cycles",
                   $sampled(cpu_addr));
        end

    hit_no_mem: assert property (@(posedge clk) disable iff (!rst_n)
        hit_pending |-> !mem_req)
        else begin
            fail_count++;
            $error("a request to a recently used line went to the line port");
        end

    unc_no_mem: assert property (@(posedge clk) disable iff (!rst_n)
        unc_pending |-> !mem_req)
        else begin
            fail_count++;
            $error("an uncached request went to the line port");
        end

    wb_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req && mem_we |-> mem_addr[dcache_pkg::offset_bits-1:0] == '0)
        else begin
            fail_count++;
            $error("CHECK FAILED mem_addr: writeback address %h is not line aligned",
                   $sampled(mem_addr));
        end

    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        !($rose(cpu_ack) && !cpu_req) && !($rose(mem_ack) && !mem_req) &&
        !($rose(unc_ack) && !unc_req))
        else begin
            fail_count++;
            $error("an ack rose while its req was low");
        end

    cpu_stable: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_req && !cpu_ack |=> $stable({cpu_we, cpu_cached, cpu_addr, cpu_wdata,
                                         cpu_wstrb, cpu_size, cpu_signed}))
        else begin
            fail_count++;
            $error("the CPU request payload changed before cpu_ack");
        end

    mem_stable: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req && !mem_ack |=> $stable({mem_we, mem_addr, mem_wline}))
        else begin
            fail_count++;
            $error("the line port payload changed before mem_ack");
        end

    unc_stable: assert property (@(posedge clk) disable iff (!rst_n)
        unc_req && !unc_ack |=> $stable({unc_we, unc_addr, unc_wdata, unc_wstrb}))
        else begin
            fail_count++;
            $error("the uncached port payload changed before unc_ack");
        end

    reset_quiet: assert property (@(posedge clk)
        !rst_n |-> !cpu_ack && !mem_req && !unc_req && !mem_ack && !unc_ack)
        else begin
            fail_count++;
            $error("a req or ack was high during reset");
        end

endmodule

bind dcache_top dcache_chk chk_i (.*);

// ==== tb/dcache_tb.sv ====
module dcache_tb;

    localparam int num_req    = 400;
    localparam int max_cycles = num_req * 60 + 16;

    logic              clk;
    logic              rst_n;
    logic              cpu_req;
    logic              cpu_we;
    logic              cpu_cached;
    dcache_pkg::addr_t cpu_addr;
    dcache_pkg::word_t cpu_wdata;
    dcache_pkg::strb_t cpu_wstrb;
    dcache_pkg::size_t cpu_size;
    logic              cpu_signed;
    logic              cpu_ack;
    dcache_pkg::word_t cpu_rdata;
    logic              mem_req;
    logic              mem_we;
    dcache_pkg::addr_t mem_addr;
    dcache_pkg::line_t mem_wline;
    logic              mem_ack;
    dcache_pkg::line_t mem_rline;
    logic              unc_req;
    logic              unc_we;
    dcache_pkg::addr_t unc_addr;
    dcache_pkg::word_t unc_wdata;
    dcache_pkg::strb_t unc_wstrb;
    logic              unc_ack;
    dcache_pkg::word_t unc_rdata;

    dcache_pkg::word_t line_mem [1024];
    dcache_pkg::word_t unc_mem [64];      // uncached words at 0x1000
    logic [31:0]       drv_seed;
    logic [31:0]       mem_seed;
    logic [31:0]       unc_seed;
    logic              mem_busy;
    logic [2:0]        mem_wait;
    logic              unc_busy;
    logic [2:0]        unc_wait;
    dcache_pkg::addr_t last_addr;
    logic              last_cached;
    int                done_count;
    int                cycles;

    dcache_top dut_i (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic cpu_access(input logic we, input logic cached, input dcache_pkg::addr_t addr,
                              input dcache_pkg::word_t wdata, input dcache_pkg::strb_t wstrb,
                              input dcache_pkg::size_t size, input logic sign);
        @(posedge clk);
        cpu_req    <= 1'b1;
        cpu_we     <= we;
        cpu_cached <= cached;
        cpu_addr   <= addr;
        cpu_wdata  <= wdata;
        cpu_wstrb  <= wstrb;
        cpu_size   <= size;
        cpu_signed <= sign;
        @(posedge clk);
        while (!cpu_ack)
            @(posedge clk);
        cpu_req <= 1'b0;
        @(posedge clk);
        while (cpu_ack)
            @(posedge clk);
        last_addr   = addr;
        last_cached = cached;
        done_count++;
    endtask

    task automatic random_access();
        logic [31:0]       r;
        logic [31:0]       r2;
        dcache_pkg::addr_t addr;
        dcache_pkg::size_t size;
        logic              cached;
        drv_seed = lcg_step(drv_seed);
        r        = drv_seed;
        drv_seed = lcg_step(drv_seed);
        r2       = drv_seed;
        drv_seed = lcg_step(drv_seed);
        cached   = 1'b1;
        case (r[31:29])
            3'd4, 3'd5: addr = {20'h0, r[27:18], 2'b00};
            3'd6: begin
                addr   = {last_addr[31:4], r[21:20], 2'b00};   // same line again
                cached = last_cached;
            end
            3'd7: begin
                addr   = 32'h1000 + {r[23:20], 2'b00};
                cached = 1'b0;
            end
            default: addr = (32'(r[27:24] % 4'd10) << 8) + 32'h90 + {r[21:20], 2'b00};
        endcase
        size = (r2[23:22] == 2'd3) ? 2'd2 : r2[23:22];
        if (size == 2'd0)
            addr[1:0] = r2[20:19];
        else if (size == 2'd1)
            addr[1:0] = {r2[20], 1'b0};
        cpu_access(r2[31], cached, addr, drv_seed,
                   (r2[27:24] == 4'h0) ? 4'hf : r2[27:24], size, r2[21]);
    endtask

    always @(posedge clk) begin : line_responder
        dcache_pkg::line_t rl;
        if (!rst_n) begin
            mem_ack  <= 1'b0;
            mem_busy <= 1'b0;
        end else if (mem_ack) begin
            if (!mem_req)
                mem_ack <= 1'b0;
        end else if (mem_req && !mem_busy) begin
            mem_seed = lcg_step(mem_seed);
            mem_wait <= mem_seed[30:28];
            mem_busy <= 1'b1;
        end else if (mem_busy && mem_wait != 3'd0) begin
            mem_wait <= mem_wait - 3'd1;
        end else if (mem_busy) begin
            for (int w = 0; w < 4; w++) begin
                if (mem_we)
                    line_mem[{mem_addr[11:4], 2'(w)}] = mem_wline[32*w +: 32];
                rl[32*w +: 32] = line_mem[{mem_addr[11:4], 2'(w)}];
            end
            mem_rline <= rl;
            mem_ack   <= 1'b1;
            mem_busy  <= 1'b0;
        end
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            unc_ack  <= 1'b0;
            unc_busy <= 1'b0;
        end else if (unc_ack) begin
            if (!unc_req)
                unc_ack <= 1'b0;
        end else if (unc_req && !unc_busy) begin
            unc_seed = lcg_step(unc_seed);
            unc_wait <= unc_seed[30:28];
            unc_busy <= 1'b1;
        end else if (unc_busy && unc_wait != 3'd0) begin
            unc_wait <= unc_wait - 3'd1;
        end else if (unc_busy) begin
            for (int b = 0; b < 4; b++) begin
                if (unc_we && unc_wstrb[b])
                    unc_mem[unc_addr[7:2]][8*b +: 8] = unc_wdata[8*b +: 8];
            end
            unc_rdata <= unc_mem[unc_addr[7:2]];
            unc_ack   <= 1'b1;
            unc_busy  <= 1'b0;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (dut_i.chk_i.fail_count != 0) begin
            $display("TEST RESULT: FAIL");
            $fatal(1, "the checker reported a failed assertion");
        end else if (cycles >= max_cycles) begin
            $display("TEST RESULT: FAIL");
            $fatal(1, "timeout after %0d cycles, the DUT hung with %0d of %0d requests done",
                   cycles, done_count, num_req);
        end
    end

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        cpu_req    = 1'b0;
        cpu_we     = 1'b0;
        cpu_cached = 1'b0;
        cpu_addr   = '0;
        cpu_wdata  = '0;
        cpu_wstrb  = '0;
        cpu_size   = '0;
        cpu_signed = 1'b0;
        mem_ack    = 1'b0;
        mem_rline  = '0;
        unc_ack    = 1'b0;
        unc_rdata  = '0;
        done_count = 0;
        cycles     = 0;
        drv_seed   = 32'd42243;
        for (int i = 0; i < 1024; i++) begin
            drv_seed                = lcg_step(drv_seed);
            line_mem[i]             = drv_seed;
            dut_i.chk_i.shadow[i]   = drv_seed;
        end
        for (int j = 0; j < 64; j++) begin
            drv_seed                     = lcg_step(drv_seed);
            unc_mem[j]                   = drv_seed;
            dut_i.chk_i.shadow[1024 + j] = drv_seed;
        end
        mem_seed = drv_seed ^ 32'h0000_1111;
        unc_seed = drv_seed ^ 32'h0000_2222;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        // four lines of set 5, touch the first, then a fifth line
        cpu_access(1'b0, 1'b1, 32'h050, '0, '0, 2'd2, 1'b0);
        cpu_access(1'b0, 1'b1, 32'h150, '0, '0, 2'd2, 1'b0);
        cpu_access(1'b0, 1'b1, 32'h250, '0, '0, 2'd2, 1'b0);
        cpu_access(1'b0, 1'b1, 32'h350, '0, '0, 2'd2, 1'b0);
        cpu_access(1'b0, 1'b1, 32'h050, '0, '0, 2'd2, 1'b0);
        cpu_access(1'b0, 1'b1, 32'h450, '0, '0, 2'd2, 1'b0);
        cpu_access(1'b0, 1'b1, 32'h054, '0, '0, 2'd2, 1'b0);
        while (done_count < num_req)
            random_access();
        repeat (4) @(posedge clk);
        if (dut_i.chk_i.fail_count != 0) begin
            $display("TEST RESULT: FAIL");
            $fatal(1, "the checker reported a failed assertion");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

// ==== compile.f ====
design/dcache_pkg.sv
design/load_align.sv
design/plru_tree.sv
design/dcache_arrays.sv
design/dcache_ctrl.sv
design/dcache_top.sv
tb/dcache_chk.sv
tb/dcache_tb.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - design/dcache_pkg.sv
  - design/load_align.sv
  - design/plru_tree.sv
  - design/dcache_arrays.sv
  - design/dcache_ctrl.sv
  - design/dcache_top.sv
  - target: simulation
    files:
      - tb/dcache_chk.sv
      - tb/dcache_tb.sv
